//--- Makefile
# Verilator build and run of the cache controller testbench

TOP = cache_controller_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module $(TOP) -f project.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || echo "=== FAIL ===" >> sim.log
	@cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

//--- project.f
+incdir+source
source/cache_bus_pkg.sv
source/cache_ctrl_pkg.sv
source/cache_lookup.sv
source/cache_sequencer.sv
source/cache_signal_gen.sv
source/cache_controller.sv
tb/cache_controller_properties.sv
tb/cache_controller_tb.sv

//--- source/cache_bus_pkg.sv
`include "cache_macros.svh"

package cache_bus_pkg;

    // what one way array reports for the addressed set
    typedef struct packed {
        logic                    hit;
        logic                    valid;
        logic                    dirty;
        logic [`CACHE_TAG_W-1:0] tag;
    } way_status_t;

    // command to both way arrays
    // only the enables are per way, the rest is shared
    typedef struct packed {
        logic [1:0]                 en;
        logic                       comp;
        logic                       write;
        logic                       valid_in;
        logic [`CACHE_OFFSET_W-1:0] offset;
        logic [`CACHE_TAG_W-1:0]    tag;
    } way_ctrl_t;

    // command to main memory
    typedef struct packed {
        logic                     rd;
        logic                     wr;
        // fill data comes from memory, not the requester
        logic                     cache_wr;
        logic [`CACHE_ADDR_W-1:0] addr;
    } mem_req_t;

endpackage

//--- source/cache_controller.sv
`timescale 1ns/100ps
`include "cache_macros.svh"

module cache_controller (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        read,
    input  logic                        write,
    input  logic [`CACHE_ADDR_W-1:0]    addr,
    input  cache_bus_pkg::way_status_t  status0,
    input  cache_bus_pkg::way_status_t  status1,
    input  logic [`CACHE_MEM_BANKS-1:0] busy,
    output logic                        done,
    output logic                        stall,
    output logic                        miss,
    output cache_bus_pkg::way_ctrl_t    way_ctrl,
    output cache_bus_pkg::mem_req_t     mem_req
);

    cache_ctrl_pkg::lookup_t     lookup;
    cache_ctrl_pkg::ctrl_state_t state;
    cache_ctrl_pkg::beat_t       beat;

    cache_lookup cache_lookup_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .state   (state),
        .status0 (status0),
        .status1 (status1),
        .lookup  (lookup)
    );

    cache_sequencer cache_sequencer_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .read   (read),
        .write  (write),
        .busy   (busy),
        .lookup (lookup),
        .state  (state),
        .beat   (beat),
        .done   (done),
        .stall  (stall),
        .miss   (miss)
    );

    cache_signal_gen cache_signal_gen_inst (
        .state    (state),
        .beat     (beat),
        .lookup   (lookup),
        .addr     (addr),
        .way_ctrl (way_ctrl),
        .mem_req  (mem_req)
    );

endmodule

//--- source/cache_ctrl_pkg.sv
`include "cache_macros.svh"

package cache_ctrl_pkg;

    typedef enum logic [3:0] {
        IDLE,
        COMP_READ,
        COMP_WRITE,
        ALLOC,
        WRITE_BACK,
        WB_STALL,
        FILL,
        FILL_DONE,
        CACHE_WRITE,
        DONE_MISS,
        DONE_HIT
    } ctrl_state_t;

    // write wins over read when both are set
    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_READ,
        REQ_WRITE
    } req_op_t;

    // fill runs line words plus memory latency beats
    typedef logic [$clog2(`CACHE_LINE_WORDS + `CACHE_MEM_LATENCY)-1:0] beat_t;

    typedef struct packed {
        logic                    hit;
        logic                    way;
        logic                    writeback;
        logic [`CACHE_TAG_W-1:0] victim_tag;
    } lookup_t;

endpackage

//--- source/cache_lookup.sv
`timescale 1ns/100ps

module cache_lookup (
    input  logic                        clk,
    input  logic                        arst_n,
    input  cache_ctrl_pkg::ctrl_state_t state,
    input  cache_bus_pkg::way_status_t  status0,
    input  cache_bus_pkg::way_status_t  status1,
    output cache_ctrl_pkg::lookup_t     lookup
);

    logic                       compare;
    logic                       hit0;
    logic                       hit1;
    logic                       way_pick;
    logic                       way_q;
    logic                       victim_q;
    logic                       way_sel;
    cache_bus_pkg::way_status_t sel;

    assign compare = (state == cache_ctrl_pkg::COMP_READ) ||
                     (state == cache_ctrl_pkg::COMP_WRITE);

    assign hit0 = status0.hit & status0.valid;
    assign hit1 = status1.hit & status1.valid;

    // hit way first, then an empty way, then the alternating victim
    always_comb begin
        if (hit1)
            way_pick = 1'b1;
        else if (hit0)
            way_pick = 1'b0;
        else if (!status0.valid)
            way_pick = 1'b0;
        else if (!status1.valid)
            way_pick = 1'b1;
        else
            way_pick = victim_q;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            way_q    <= 1'b0;
            victim_q <= 1'b0;
        end else if (compare) begin
            way_q    <= way_pick;
            victim_q <= ~victim_q;
        end
    end

    // the sequencer needs the choice already during compare
    assign way_sel = compare ? way_pick : way_q;
    assign sel     = way_sel ? status1 : status0;

    assign lookup.hit        = hit0 | hit1;
    assign lookup.way        = way_sel;
    assign lookup.writeback  = sel.valid & sel.dirty;
    assign lookup.victim_tag = sel.tag;

endmodule

//--- source/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// word address splits as tag | index | offset
`define CACHE_ADDR_W      16
`define CACHE_TAG_W       5
`define CACHE_INDEX_W     8

// upper offset bits pick the word, bit 0 the half-word
`define CACHE_OFFSET_W    3

`define CACHE_LINE_WORDS  4

// cycles from a memory read strobe to its data
`define CACHE_MEM_LATENCY 2

// one busy bit per memory bank
`define CACHE_MEM_BANKS   4

`endif

//--- source/cache_sequencer.sv
`timescale 1ns/100ps
`include "cache_macros.svh"

module cache_sequencer (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          read,
    input  logic                          write,
    input  logic [`CACHE_MEM_BANKS-1:0]   busy,
    input  cache_ctrl_pkg::lookup_t       lookup,
    output cache_ctrl_pkg::ctrl_state_t   state,
    output cache_ctrl_pkg::beat_t         beat,
    output logic                          done,
    output logic                          stall,
    output logic                          miss
);

    localparam int WB_BEATS   = `CACHE_LINE_WORDS;
    localparam int FILL_BEATS = `CACHE_LINE_WORDS + `CACHE_MEM_LATENCY;

    cache_ctrl_pkg::req_op_t     op;
    cache_ctrl_pkg::req_op_t     op_q;
    cache_ctrl_pkg::ctrl_state_t state_nxt;

    assign op = write ? cache_ctrl_pkg::REQ_WRITE :
                read  ? cache_ctrl_pkg::REQ_READ  : cache_ctrl_pkg::REQ_NONE;

    always_comb begin
        state_nxt = state;
        case (state)
            cache_ctrl_pkg::IDLE: begin
                if (op == cache_ctrl_pkg::REQ_WRITE)
                    state_nxt = cache_ctrl_pkg::COMP_WRITE;
                else if (op == cache_ctrl_pkg::REQ_READ)
                    state_nxt = cache_ctrl_pkg::COMP_READ;
            end
            cache_ctrl_pkg::COMP_READ: begin
                if (lookup.hit)
                    state_nxt = cache_ctrl_pkg::DONE_HIT;
                else if (lookup.writeback)
                    state_nxt = cache_ctrl_pkg::WRITE_BACK;
                else
                    state_nxt = cache_ctrl_pkg::FILL;
            end
            cache_ctrl_pkg::COMP_WRITE:
                state_nxt = lookup.hit ? cache_ctrl_pkg::DONE_HIT : cache_ctrl_pkg::ALLOC;
            cache_ctrl_pkg::ALLOC:
                state_nxt = lookup.writeback ? cache_ctrl_pkg::WRITE_BACK : cache_ctrl_pkg::FILL;
            cache_ctrl_pkg::WRITE_BACK: begin
                if (beat == cache_ctrl_pkg::beat_t'(WB_BEATS - 1))
                    state_nxt = cache_ctrl_pkg::WB_STALL;
            end
            // wait for every bank to drain the write-back
            cache_ctrl_pkg::WB_STALL: begin
                if (busy == '0)
                    state_nxt = cache_ctrl_pkg::FILL;
            end
            cache_ctrl_pkg::FILL: begin
                if (beat == cache_ctrl_pkg::beat_t'(FILL_BEATS - 1))
                    state_nxt = (op_q == cache_ctrl_pkg::REQ_WRITE) ?
                                cache_ctrl_pkg::CACHE_WRITE : cache_ctrl_pkg::FILL_DONE;
            end
            cache_ctrl_pkg::FILL_DONE,
            cache_ctrl_pkg::CACHE_WRITE:
                state_nxt = cache_ctrl_pkg::DONE_MISS;
            default:
                state_nxt = cache_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= cache_ctrl_pkg::IDLE;
            beat  <= '0;
            op_q  <= cache_ctrl_pkg::REQ_NONE;
        end else begin
            state <= state_nxt;
            if (state == cache_ctrl_pkg::IDLE)
                op_q <= op;
            // beats count only while staying in a burst state
            if (state_nxt == state && (state == cache_ctrl_pkg::WRITE_BACK ||
                                       state == cache_ctrl_pkg::FILL))
                beat <= beat + 1'b1;
            else
                beat <= '0;
        end
    end

    assign done  = (state == cache_ctrl_pkg::DONE_HIT) || (state == cache_ctrl_pkg::DONE_MISS);
    assign stall = (state != cache_ctrl_pkg::IDLE);
    assign miss  = state inside {cache_ctrl_pkg::ALLOC, cache_ctrl_pkg::WRITE_BACK,
                                 cache_ctrl_pkg::WB_STALL, cache_ctrl_pkg::FILL,
                                 cache_ctrl_pkg::FILL_DONE, cache_ctrl_pkg::CACHE_WRITE,
                                 cache_ctrl_pkg::DONE_MISS};

endmodule

//--- source/cache_signal_gen.sv
`timescale 1ns/100ps
`include "cache_macros.svh"

module cache_signal_gen (
    input  cache_ctrl_pkg::ctrl_state_t state,
    input  cache_ctrl_pkg::beat_t       beat,
    input  cache_ctrl_pkg::lookup_t     lookup,
    input  logic [`CACHE_ADDR_W-1:0]    addr,
    output cache_bus_pkg::way_ctrl_t    way_ctrl,
    output cache_bus_pkg::mem_req_t     mem_req
);

    logic [`CACHE_TAG_W-1:0]    req_tag;
    logic [`CACHE_INDEX_W-1:0]  req_index;
    logic [`CACHE_OFFSET_W-1:0] req_offset;
    logic [`CACHE_OFFSET_W-2:0] beat_word;
    logic [`CACHE_OFFSET_W-2:0] fill_word;
    cache_ctrl_pkg::beat_t      fill_beat;

    assign req_tag    = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign req_index  = addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign req_offset = addr[`CACHE_OFFSET_W-1:0];

    // memory side handles word k on beat k, the array lags by the latency
    assign beat_word = beat[`CACHE_OFFSET_W-2:0];
    assign fill_beat = beat - cache_ctrl_pkg::beat_t'(`CACHE_MEM_LATENCY);
    assign fill_word = fill_beat[`CACHE_OFFSET_W-2:0];

    always_comb begin
        way_ctrl = '0;
        mem_req  = '0;

        if (state != cache_ctrl_pkg::IDLE) begin
            way_ctrl.en     = lookup.way ? 2'b10 : 2'b01;
            way_ctrl.offset = req_offset;
            way_ctrl.tag    = req_tag;
            mem_req.addr    = addr;
        end

        case (state)
            cache_ctrl_pkg::COMP_READ,
            cache_ctrl_pkg::COMP_WRITE: begin
                way_ctrl.en    = 2'b11;
                way_ctrl.comp  = 1'b1;
                way_ctrl.write = (state == cache_ctrl_pkg::COMP_WRITE);
            end
            // victim line goes out under its stored tag
            cache_ctrl_pkg::WRITE_BACK: begin
                mem_req.wr      = 1'b1;
                mem_req.addr    = {lookup.victim_tag, req_index, beat_word, addr[0]};
                way_ctrl.offset = {beat_word, addr[0]};
            end
            cache_ctrl_pkg::FILL: begin
                if (beat < cache_ctrl_pkg::beat_t'(`CACHE_LINE_WORDS)) begin
                    mem_req.rd   = 1'b1;
                    mem_req.addr = {req_tag, req_index, beat_word, addr[0]};
                end
                if (beat >= cache_ctrl_pkg::beat_t'(`CACHE_MEM_LATENCY)) begin
                    way_ctrl.write    = 1'b1;
                    way_ctrl.valid_in = 1'b1;
                    way_ctrl.offset   = {fill_word, addr[0]};
                    mem_req.cache_wr  = 1'b1;
                end
            end
            cache_ctrl_pkg::CACHE_WRITE: begin
                way_ctrl.comp     = 1'b1;
                way_ctrl.write    = 1'b1;
                way_ctrl.valid_in = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- tb/cache_controller_properties.sv
`timescale 1ns/100ps

module cache_controller_properties (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     done,
    input logic                     stall,
    input logic                     miss,
    input cache_bus_pkg::way_ctrl_t way_ctrl,
    input cache_bus_pkg::mem_req_t  mem_req
);

    done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
        else $error("done held for more than one cycle");

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_req.rd && mem_req.wr))
        else $error("memory read and write strobes high together");

    idle_after_done: assert property (@(posedge clk) disable iff (!arst_n) done |=> !stall)
        else $error("stall still high in the cycle after done");

    // a compare that missed must not finish the request
    no_done_on_compare_miss: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(done) |-> !(miss && way_ctrl.comp))
        else $error("done rose while miss and compare were both high");

endmodule

bind cache_controller cache_controller_properties cache_controller_properties_inst (.*);

//--- tb/cache_controller_tb.sv
`timescale 1ns/100ps
`include "cache_macros.svh"

module cache_controller_tb;

    typedef logic [`CACHE_ADDR_W-1:0]    addr_t;
    typedef logic [`CACHE_MEM_BANKS-1:0] busy_t;

    // six requests with generous room each, plus reset
    localparam int TIMEOUT_CYCLES = 6 * 60 + 40;

    logic                        clk;
    logic                        arst_n;
    logic                        read;
    logic                        write;
    addr_t                       addr;
    cache_bus_pkg::way_status_t  status0;
    cache_bus_pkg::way_status_t  status1;
    busy_t                       busy;
    logic                        done;
    logic                        stall;
    logic                        miss;
    cache_bus_pkg::way_ctrl_t    way_ctrl;
    cache_bus_pkg::mem_req_t     mem_req;

    // way arrays, indexed by way and set
    logic [`CACHE_TAG_W-1:0]   tag_mem   [2][1 << `CACHE_INDEX_W];
    logic                      valid_mem [2][1 << `CACHE_INDEX_W];
    logic                      dirty_mem [2][1 << `CACHE_INDEX_W];
    logic [`CACHE_INDEX_W-1:0] idx;

    int   seed = 22885;
    int   errors;
    int   tests;
    int   failed;
    int   cycle_count;
    int   n_cycles;
    int   n_cache_wr;
    logic miss_seen;
    logic victim;
    cache_bus_pkg::mem_req_t  rd_q[$];
    cache_bus_pkg::mem_req_t  wr_q[$];
    cache_bus_pkg::way_ctrl_t fill_q[$];
    cache_bus_pkg::way_ctrl_t cw_ctrl;
    cache_bus_pkg::way_ctrl_t last_ctrl;

    cache_controller cache_controller_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles without a verdict", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // the arrays compare tags themselves, valid is reported apart
    assign idx = addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign status0 = {tag_mem[0][idx] == addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W],
                      valid_mem[0][idx], dirty_mem[0][idx], tag_mem[0][idx]};
    assign status1 = {tag_mem[1][idx] == addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W],
                      valid_mem[1][idx], dirty_mem[1][idx], tag_mem[1][idx]};

    function automatic addr_t make_addr(input int tag, input int s, input int off);
        return {tag[`CACHE_TAG_W-1:0], s[`CACHE_INDEX_W-1:0], off[`CACHE_OFFSET_W-1:0]};
    endfunction

    task automatic set_line(input int w, input int s, input int tag, input logic v, input logic d);
        tag_mem[w][s]   = tag[`CACHE_TAG_W-1:0];
        valid_mem[w][s] = v;
        dirty_mem[w][s] = d;
    endtask

    task automatic array_write(input cache_bus_pkg::way_ctrl_t c);
        for (int w = 0; w < 2; w++) begin
            if (c.en[w] && c.write) begin
                if (c.comp) begin
                    // a processor write lands only on a matching line
                    if (valid_mem[w][idx] && tag_mem[w][idx] == c.tag)
                        dirty_mem[w][idx] = 1'b1;
                end else begin
                    tag_mem[w][idx]   = c.tag;
                    valid_mem[w][idx] = c.valid_in;
                    dirty_mem[w][idx] = 1'b0;
                end
            end
        end
    endtask

    task automatic check_ctrl(input string name, input cache_bus_pkg::way_ctrl_t got, exp);
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_mem(input string name, input cache_bus_pkg::mem_req_t got, exp);
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, exp);
        if (got != exp) begin
            errors++;
            $display("ERR t=%0t %s got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors > errors_before) begin
            failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // holds the request until done, recording what the controller drives
    task automatic run_request(input logic is_write, input addr_t a, input int busy_cycles);
        int k;
        int stall_left;
        k = 0;
        stall_left = 0;
        n_cycles = 0;
        n_cache_wr = 0;
        miss_seen = 1'b0;
        cw_ctrl = '0;
        rd_q.delete();
        wr_q.delete();
        fill_q.delete();
        @(posedge clk);
        #1;
        read  = !is_write;
        write = is_write;
        addr  = a;
        while (n_cycles == 0) begin
            @(posedge clk);
            #1;
            // banks stay busy for a while once the write-back is out
            busy = (stall_left > 0) ? (busy_t'($random(seed)) | busy_t'(1)) : '0;
            if (stall_left > 0)
                stall_left--;
            @(negedge clk);
            check_bit("stall during request", stall, 1'b1);
            if (mem_req.rd)
                rd_q.push_back(mem_req);
            if (mem_req.wr)
                wr_q.push_back(mem_req);
            if (mem_req.wr && wr_q.size() == `CACHE_LINE_WORDS)
                stall_left = busy_cycles;
            if (mem_req.cache_wr)
                n_cache_wr++;
            if (way_ctrl.write && !way_ctrl.comp)
                fill_q.push_back(way_ctrl);
            else if (way_ctrl.write && way_ctrl.en != 2'b11)
                cw_ctrl = way_ctrl;
            miss_seen = miss_seen | miss;
            last_ctrl = way_ctrl;
            // the array commits at the next edge and nothing reads it before
            array_write(way_ctrl);
            k++;
            if (done)
                n_cycles = k;
        end
        @(posedge clk);
        #1;
        read   = 1'b0;
        write  = 1'b0;
        victim = ~victim;
    endtask

    task automatic check_fill(input addr_t a, input logic [1:0] way_en);
        cache_bus_pkg::mem_req_t  mexp;
        cache_bus_pkg::way_ctrl_t cexp;
        check_count("fill reads", rd_q.size(), `CACHE_LINE_WORDS);
        check_count("fill way writes", fill_q.size(), `CACHE_LINE_WORDS);
        check_count("cache_wr beats", n_cache_wr, `CACHE_LINE_WORDS);
        for (int k = 0; k < rd_q.size() && k < fill_q.size(); k++) begin
            // memory data trails the read by the latency
            mexp = '{rd: 1'b1, wr: 1'b0, cache_wr: k >= `CACHE_MEM_LATENCY,
                     addr: {a[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], k[1:0], a[0]}};
            check_mem($sformatf("fill read %0d", k), rd_q[k], mexp);
            cexp = '{en: way_en, comp: 1'b0, write: 1'b1, valid_in: 1'b1,
                     offset: {k[1:0], a[0]}, tag: a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W]};
            check_ctrl($sformatf("fill write %0d", k), fill_q[k], cexp);
        end
    endtask

    task automatic idle_outputs(input string when);
        check_bit({"done ", when}, done, 1'b0);
        check_bit({"stall ", when}, stall, 1'b0);
        check_bit({"miss ", when}, miss, 1'b0);
        check_ctrl({"way_ctrl ", when}, way_ctrl, '0);
        check_mem({"mem_req ", when}, mem_req, '0);
    endtask

    task automatic reset_outputs();
        int e0;
        e0 = errors;
        @(posedge clk);
        @(negedge clk);
        idle_outputs("in reset");
        @(posedge clk);
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        idle_outputs("after reset");
        finish_test("reset", e0);
    endtask

    task automatic read_hit_way1();
        int                       e0;
        addr_t                    a;
        cache_bus_pkg::way_ctrl_t cexp;
        e0 = errors;
        a = make_addr(3, 10, 5);
        set_line(0, 10, 7, 1'b1, 1'b0);
        set_line(1, 10, 3, 1'b1, 1'b0);
        run_request(1'b0, a, 0);
        check_count("hit cycles", n_cycles, 2);
        check_bit("miss on hit", miss_seen, 1'b0);
        check_count("memory strobes on hit", rd_q.size() + wr_q.size(), 0);
        cexp = '{en: 2'b10, comp: 1'b0, write: 1'b0, valid_in: 1'b0,
                 offset: a[`CACHE_OFFSET_W-1:0], tag: a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W]};
        check_ctrl("way_ctrl after compare", last_ctrl, cexp);
        finish_test("read hit way 1", e0);
    endtask

    task automatic clean_read_miss();
        int    e0;
        addr_t a;
        e0 = errors;
        a = make_addr(9, 20, 3);
        run_request(1'b0, a, 0);
        check_count("clean read miss cycles", n_cycles, 9);
        check_bit("miss on read miss", miss_seen, 1'b1);
        check_count("write-back beats", wr_q.size(), 0);
        // both ways empty so way 0 takes the line
        check_fill(a, 2'b01);
        finish_test("clean read miss", e0);
    endtask

    task automatic dirty_write_miss();
        int                       e0;
        int                       wait_cycles;
        int                       vtag;
        addr_t                    a;
        logic [1:0]               way_en;
        cache_bus_pkg::mem_req_t  mexp;
        cache_bus_pkg::way_ctrl_t cexp;
        e0 = errors;
        a = make_addr(12, 40, 6);
        set_line(0, 40, 1, 1'b1, 1'b1);
        set_line(1, 40, 2, 1'b1, 1'b1);
        way_en = victim ? 2'b10 : 2'b01;
        vtag = victim ? 2 : 1;
        wait_cycles = 1 + ($random(seed) & 3);
        run_request(1'b1, a, wait_cycles);
        check_count("dirty write miss cycles", n_cycles, 10 + 4 + wait_cycles + 1);
        check_bit("miss on write miss", miss_seen, 1'b1);
        check_count("write-back beats", wr_q.size(), `CACHE_LINE_WORDS);
        for (int k = 0; k < wr_q.size(); k++) begin
            mexp = '{rd: 1'b0, wr: 1'b1, cache_wr: 1'b0,
                     addr: {vtag[`CACHE_TAG_W-1:0], a[`CACHE_OFFSET_W +: `CACHE_INDEX_W],
                            k[1:0], a[0]}};
            check_mem($sformatf("write-back %0d", k), wr_q[k], mexp);
        end
        check_fill(a, way_en);
        cexp = '{en: way_en, comp: 1'b1, write: 1'b1, valid_in: 1'b1,
                 offset: a[`CACHE_OFFSET_W-1:0], tag: a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W]};
        check_ctrl("cache write", cw_ctrl, cexp);
        finish_test("dirty write miss", e0);
    endtask

    task automatic way_choice();
        int         e0;
        addr_t      a;
        logic [1:0] way_en;
        e0 = errors;
        // the empty way wins over the victim
        set_line(0, 60, 4, 1'b1, 1'b0);
        a = make_addr(5, 60, 0);
        run_request(1'b0, a, 0);
        check_fill(a, 2'b10);
        set_line(0, 61, 1, 1'b1, 1'b0);
        set_line(1, 61, 2, 1'b1, 1'b0);
        for (int i = 0; i < 2; i++) begin
            way_en = victim ? 2'b10 : 2'b01;
            a = make_addr(3 + i, 61, 4);
            run_request(1'b0, a, 0);
            check_fill(a, way_en);
        end
        finish_test("way choice", e0);
    endtask

    initial begin
        arst_n = 1'b0;
        read   = 1'b0;
        write  = 1'b0;
        addr   = '0;
        busy   = '0;
        victim = 1'b0;
        for (int s = 0; s < (1 << `CACHE_INDEX_W); s++) begin
            set_line(0, s, 0, 1'b0, 1'b0);
            set_line(1, s, 0, 1'b0, 1'b0);
        end
        reset_outputs();
        read_hit_way1();
        clean_read_miss();
        dirty_write_miss();
        way_choice();
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
